//--- logic/dcache_pkg.sv
package dcache_pkg;

    localparam int addr_bits = 32;
    localparam int block_bits = 64;
    localparam int block_offset_bits = 3;   // 8 bytes per line

    typedef logic [addr_bits-1:0] addr_t;

    // one cache line, seen at any access width
    typedef union packed {
        logic [block_bits-1:0] raw;
        logic [7:0][7:0]       bytes;
        logic [3:0][15:0]      halves;
        logic [1:0][31:0]      words;
    } block_t;

    typedef logic [3:0] mem_tag_t;

    localparam mem_tag_t tag_none = '0;   // memory gave no response

    typedef enum logic [1:0] {
        cmd_none  = 2'h0,
        cmd_load  = 2'h1,
        cmd_store = 2'h2
    } mem_command_e;

    typedef enum logic [1:0] {
        size_byte = 2'h0,
        size_half = 2'h1,
        size_word = 2'h2
    } mem_size_e;

    typedef enum logic [1:0] {
        st_ready,
        st_wait_mshr,   // miss seen, too few free entries
        st_wait_fill
    } cache_state_e;

endpackage

//--- logic/mshr_if.sv
`timescale 1ns/1ps

interface mshr_if;
    import dcache_pkg::*;

    logic     busy;
    logic     load_en;        // one-cycle strobe from the allocator
    logic     load_write;
    addr_t    load_addr;
    block_t   load_data;
    logic     pending_write;
    logic     pending_read;
    addr_t    addr;
    block_t   data;
    mem_tag_t read_tag;       // tag of the issued read, tag_none otherwise
    logic     grant;          // pulses only when memory accepts
    mem_tag_t grant_tag;
    logic     fill;

    modport entry (
        input  load_en, load_write, load_addr, load_data, grant, grant_tag, fill,
        output busy, pending_write, pending_read, addr, data, read_tag
    );

    modport alloc (
        input  busy,
        output load_en, load_write, load_addr, load_data
    );

    modport issue (
        input  pending_write, pending_read, addr, data, read_tag,
        output grant, grant_tag, fill
    );

endinterface

//--- logic/dcache_lines.sv
`timescale 1ns/1ps

module dcache_lines #(
    parameter int num_lines = 8
) (
    input  logic                  clock,
    input  logic                  reset,
    input  dcache_pkg::addr_t     lookup_addr,
    input  dcache_pkg::mem_size_e lookup_size,
    input  logic                  store_en,
    input  logic [31:0]           store_data,
    input  logic                  fill,
    input  dcache_pkg::addr_t     fill_addr,
    input  dcache_pkg::block_t    fill_data,
    output logic                  hit,
    output dcache_pkg::block_t    line_data,
    output logic                  evict,
    output dcache_pkg::addr_t     evict_addr,
    output dcache_pkg::block_t    evict_data
);
    import dcache_pkg::*;

    localparam int index_bits = $clog2(num_lines);
    localparam int tag_bits = addr_bits - index_bits - block_offset_bits;

    logic [num_lines-1:0] valid;
    logic [num_lines-1:0] dirty;
    logic [tag_bits-1:0]  tags [num_lines];
    block_t               lines [num_lines];

    logic [index_bits-1:0] lookup_idx;
    logic [index_bits-1:0] fill_idx;
    logic [tag_bits-1:0]   lookup_tag;
    logic [tag_bits-1:0]   fill_tag;
    block_t                store_base;
    block_t                merged;

    assign lookup_idx = lookup_addr[block_offset_bits +: index_bits];
    assign lookup_tag = lookup_addr[addr_bits-1 -: tag_bits];
    assign fill_idx   = fill_addr[block_offset_bits +: index_bits];
    assign fill_tag   = fill_addr[addr_bits-1 -: tag_bits];

    assign hit       = valid[lookup_idx] && (tags[lookup_idx] == lookup_tag);
    assign line_data = lines[lookup_idx];

    // the line sitting at the fill index is the victim
    assign evict      = fill && valid[fill_idx] && dirty[fill_idx];
    assign evict_addr = {tags[fill_idx], fill_idx, {block_offset_bits{1'b0}}};
    assign evict_data = lines[fill_idx];

    // a held store merges straight into the incoming line
    assign store_base = fill ? fill_data : lines[lookup_idx];

    always_comb begin
        merged = store_base;
        case (lookup_size)
            size_byte: merged.bytes[lookup_addr[block_offset_bits-1:0]] = store_data[7:0];
            size_half: merged.halves[lookup_addr[block_offset_bits-1:1]] = store_data[15:0];
            default:   merged.words[lookup_addr[block_offset_bits-1]] = store_data;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
            dirty <= '0;
        end else if (fill) begin
            valid[fill_idx] <= 1'b1;
            dirty[fill_idx] <= store_en;    // clean unless a store lands with it
        end else if (store_en) begin
            dirty[lookup_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fill) begin
            tags[fill_idx]  <= fill_tag;
            lines[fill_idx] <= store_en ? merged : fill_data;
        end else if (store_en) begin
            lines[lookup_idx] <= merged;
        end
    end

endmodule

//--- logic/dcache_control.sv
`timescale 1ns/1ps

module dcache_control #(
    parameter int num_mshr = 4
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          req_valid,
    input  logic                          req_store,
    input  dcache_pkg::addr_t             req_addr,
    input  dcache_pkg::mem_size_e         req_size,
    input  logic [31:0]                   req_wdata,
    input  logic                          hit,
    input  dcache_pkg::block_t            line_data,
    input  logic                          fill,
    input  dcache_pkg::addr_t             fill_addr,
    input  dcache_pkg::block_t            fill_data,
    input  logic [$clog2(num_mshr+1)-1:0] free_count,
    output logic                          stall,
    output logic                          resp_valid,
    output logic [31:0]                   resp_rdata,
    output dcache_pkg::addr_t             lookup_addr,
    output dcache_pkg::mem_size_e         lookup_size,
    output logic                          store_en,
    output logic [31:0]                   store_data,
    output logic                          miss,
    output dcache_pkg::addr_t             miss_addr
);
    import dcache_pkg::*;

    cache_state_e state;
    cache_state_e next_state;

    logic        held_store;
    addr_t       held_addr;
    mem_size_e   held_size;
    logic [31:0] held_wdata;

    logic   in_ready;
    logic   ready_hit;
    logic   ready_miss;
    logic   fill_done;
    logic   enough_free;
    block_t resp_line;

    assign in_ready    = (state == st_ready);
    assign ready_hit   = in_ready && req_valid && hit;
    assign ready_miss  = in_ready && req_valid && !hit;
    assign enough_free = (free_count >= 2);   // read miss plus room for its write-back

    // fill for the held line ends the wait
    assign fill_done = (state == st_wait_fill) && fill &&
                       (fill_addr[addr_bits-1:block_offset_bits] ==
                        held_addr[addr_bits-1:block_offset_bits]);

    assign lookup_addr = in_ready ? req_addr : held_addr;
    assign lookup_size = in_ready ? req_size : held_size;
    assign store_data  = in_ready ? req_wdata : held_wdata;

    assign store_en  = (ready_hit && req_store) || (fill_done && held_store);
    assign miss      = enough_free && (ready_miss || state == st_wait_mshr);
    assign miss_addr = {lookup_addr[addr_bits-1:block_offset_bits], {block_offset_bits{1'b0}}};
    assign stall     = !in_ready;

    always_comb begin
        next_state = state;
        case (state)
            st_ready: begin
                if (ready_miss) begin
                    next_state = enough_free ? st_wait_fill : st_wait_mshr;
                end
            end
            st_wait_mshr: begin
                if (enough_free) begin
                    next_state = st_wait_fill;
                end
            end
            st_wait_fill: begin
                if (fill_done) begin
                    next_state = st_ready;
                end
            end
            default: next_state = st_ready;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= st_ready;
            resp_valid <= 1'b0;
        end else begin
            state      <= next_state;
            resp_valid <= ready_hit || fill_done;
        end
    end

    // the request is captured while ready and held through a miss
    always_ff @(posedge clock) begin
        if (in_ready) begin
            held_store <= req_store;
            held_addr  <= req_addr;
            held_size  <= req_size;
            held_wdata <= req_wdata;
        end
    end

    assign resp_line = fill_done ? fill_data : line_data;

    always_ff @(posedge clock) begin
        case (lookup_size)   // zero extended
            size_byte: resp_rdata <= {24'h0, resp_line.bytes[lookup_addr[block_offset_bits-1:0]]};
            size_half: resp_rdata <= {16'h0, resp_line.halves[lookup_addr[block_offset_bits-1:1]]};
            default:   resp_rdata <= resp_line.words[lookup_addr[block_offset_bits-1]];
        endcase
    end

endmodule

//--- logic/mshr_alloc.sv
`timescale 1ns/1ps

module mshr_alloc #(
    parameter int num_mshr = 4
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          miss,
    input  dcache_pkg::addr_t             miss_addr,
    input  logic                          evict,
    input  dcache_pkg::addr_t             evict_addr,
    input  dcache_pkg::block_t            evict_data,
    output logic [$clog2(num_mshr+1)-1:0] free_count,
    mshr_if.alloc                         ports [num_mshr]
);
    localparam int count_bits = $clog2(num_mshr + 1);

    logic [num_mshr-1:0]   busy;
    logic [num_mshr-1:0]   load_wb;
    logic [num_mshr-1:0]   load_rd;
    logic [count_bits-1:0] free_now;

    for (genvar g = 0; g < num_mshr; g++) begin : g_port
        assign busy[g]             = ports[g].busy;
        assign ports[g].load_en    = load_wb[g] | load_rd[g];
        assign ports[g].load_write = load_wb[g];
        assign ports[g].load_addr  = load_wb[g] ? evict_addr : miss_addr;
        assign ports[g].load_data  = evict_data;    // only kept by write-backs
    end

    // write-back takes the lowest free entry, the read miss the next one
    always_comb begin : pick
        logic wb_left;
        logic rd_left;
        wb_left  = evict;
        rd_left  = miss;
        load_wb  = '0;
        load_rd  = '0;
        free_now = '0;
        for (int i = 0; i < num_mshr; i++) begin
            if (!busy[i]) begin
                if (wb_left) begin
                    load_wb[i] = 1'b1;
                    wb_left    = 1'b0;
                end else if (rd_left) begin
                    load_rd[i] = 1'b1;
                    rd_left    = 1'b0;
                end else begin
                    free_now = free_now + 1'b1;
                end
            end
        end
    end

    // entries freed at this edge show up one cycle late, so the count never overstates
    always_ff @(posedge clock) begin
        if (reset) begin
            free_count <= count_bits'(num_mshr);
        end else begin
            free_count <= free_now;
        end
    end

endmodule

//--- logic/mshr_entry.sv
`timescale 1ns/1ps

module mshr_entry (
    input logic   clock,
    input logic   reset,
    mshr_if.entry port
);
    import dcache_pkg::*;

    logic     valid;
    logic     write;
    logic     issued;   // read sent, waiting on its tag
    mem_tag_t tag;
    addr_t    addr;
    block_t   data;

    always_ff @(posedge clock) begin
        if (reset) begin
            valid  <= 1'b0;
            issued <= 1'b0;
        end else if (port.load_en) begin
            valid  <= 1'b1;
            issued <= 1'b0;
        end else if (port.grant) begin
            valid  <= !write;   // a write is finished once memory takes it
            issued <= !write;
        end else if (port.fill) begin
            valid  <= 1'b0;
            issued <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (port.load_en) begin
            write <= port.load_write;
            addr  <= port.load_addr;
            data  <= port.load_data;
        end
        if (port.grant) begin
            tag <= port.grant_tag;
        end
    end

    assign port.busy          = valid;
    assign port.pending_write = valid && write && !issued;
    assign port.pending_read  = valid && !write && !issued;
    assign port.addr          = addr;
    assign port.data          = data;
    assign port.read_tag      = (valid && issued) ? tag : tag_none;

endmodule

//--- logic/mem_issue.sv
`timescale 1ns/1ps

module mem_issue #(
    parameter int num_mshr = 4
) (
    input  dcache_pkg::mem_tag_t      mem_response,
    input  dcache_pkg::block_t        mem_rdata,
    input  dcache_pkg::mem_tag_t      mem_rtag,
    mshr_if.issue                     ports [num_mshr],
    output dcache_pkg::mem_command_e  mem_command,
    output dcache_pkg::addr_t         mem_addr,
    output dcache_pkg::block_t        mem_wdata,
    output logic                      fill,
    output dcache_pkg::addr_t         fill_addr,
    output dcache_pkg::block_t        fill_data
);
    import dcache_pkg::*;

    localparam int sel_bits = (num_mshr > 1) ? $clog2(num_mshr) : 1;

    logic [num_mshr-1:0] pend_wr;
    logic [num_mshr-1:0] pend_rd;
    logic [num_mshr-1:0] fill_hit;
    addr_t               entry_addr [num_mshr];
    block_t              entry_data [num_mshr];
    logic [sel_bits-1:0] sel;
    logic                sel_valid;
    logic                write_first;
    logic                accepted;

    assign accepted = (mem_response != tag_none);

    for (genvar g = 0; g < num_mshr; g++) begin : g_port
        assign pend_wr[g]    = ports[g].pending_write;
        assign pend_rd[g]    = ports[g].pending_read;
        assign entry_addr[g] = ports[g].addr;
        assign entry_data[g] = ports[g].data;
        assign fill_hit[g]   = (mem_rtag != tag_none) && (ports[g].read_tag == mem_rtag);

        assign ports[g].grant     = sel_valid && accepted && (sel == g);
        assign ports[g].grant_tag = mem_response;
        assign ports[g].fill      = fill_hit[g];
    end

    // writes drain before any read so a refetch sees written-back data
    assign write_first = |pend_wr;

    always_comb begin : pick
        sel       = '0;
        sel_valid = 1'b0;
        for (int i = num_mshr - 1; i >= 0; i--) begin   // lowest index wins
            if (write_first ? pend_wr[i] : pend_rd[i]) begin
                sel       = sel_bits'(i);
                sel_valid = 1'b1;
            end
        end
    end

    assign mem_command = !sel_valid ? cmd_none : (write_first ? cmd_store : cmd_load);
    assign mem_addr    = sel_valid ? entry_addr[sel] : '0;
    assign mem_wdata   = (sel_valid && write_first) ? entry_data[sel] : '0;

    always_comb begin : route
        fill_addr = '0;
        for (int i = 0; i < num_mshr; i++) begin
            if (fill_hit[i]) begin
                fill_addr = entry_addr[i];
            end
        end
    end

    assign fill      = |fill_hit;
    assign fill_data = mem_rdata;

endmodule

//--- logic/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
    parameter int num_lines = 8,
    parameter int num_mshr  = 4
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     req_valid,
    input  logic                     req_store,
    input  dcache_pkg::addr_t        req_addr,
    input  dcache_pkg::mem_size_e    req_size,
    input  logic [31:0]              req_wdata,
    output logic                     stall,
    output logic                     resp_valid,
    output logic [31:0]              resp_rdata,
    output dcache_pkg::mem_command_e mem_command,
    output dcache_pkg::addr_t        mem_addr,
    output dcache_pkg::block_t       mem_wdata,
    input  dcache_pkg::mem_tag_t     mem_response,
    input  dcache_pkg::block_t       mem_rdata,
    input  dcache_pkg::mem_tag_t     mem_rtag
);
    import dcache_pkg::*;

    localparam int count_bits = $clog2(num_mshr + 1);

    addr_t                 lookup_addr;
    mem_size_e             lookup_size;
    logic                  store_en;
    logic [31:0]           store_data;
    logic                  hit;
    block_t                line_data;
    logic                  miss;
    addr_t                 miss_addr;
    logic                  evict;
    addr_t                 evict_addr;
    block_t                evict_data;
    logic                  fill;
    addr_t                 fill_addr;
    block_t                fill_data;
    logic [count_bits-1:0] free_count;

    mshr_if mshr_ports [num_mshr] ();

    dcache_control #(.num_mshr(num_mshr)) u_control (
        .clock, .reset,
        .req_valid, .req_store, .req_addr, .req_size, .req_wdata,
        .hit, .line_data,
        .fill, .fill_addr, .fill_data,
        .free_count,
        .stall, .resp_valid, .resp_rdata,
        .lookup_addr, .lookup_size, .store_en, .store_data,
        .miss, .miss_addr
    );

    dcache_lines #(.num_lines(num_lines)) u_lines (
        .clock, .reset,
        .lookup_addr, .lookup_size, .store_en, .store_data,
        .fill, .fill_addr, .fill_data,
        .hit, .line_data,
        .evict, .evict_addr, .evict_data
    );

    mshr_alloc #(.num_mshr(num_mshr)) u_alloc (
        .clock, .reset,
        .miss, .miss_addr,
        .evict, .evict_addr, .evict_data,
        .free_count,
        .ports (mshr_ports)
    );

    // identical miss entries
    for (genvar g = 0; g < num_mshr; g++) begin : g_mshr
        mshr_entry u_entry (
            .clock,
            .reset,
            .port (mshr_ports[g])
        );
    end

    mem_issue #(.num_mshr(num_mshr)) u_issue (
        .mem_response, .mem_rdata, .mem_rtag,
        .ports (mshr_ports),
        .mem_command, .mem_addr, .mem_wdata,
        .fill, .fill_addr, .fill_data
    );

endmodule

//--- testbench/dcache_checker.sv
`timescale 1ns/1ps

module dcache_checker (
    input logic                     clock,
    input logic                     reset,
    input logic                     stall,
    input logic                     resp_valid,
    input dcache_pkg::mem_command_e mem_command,
    input dcache_pkg::addr_t        mem_addr,
    input dcache_pkg::mem_tag_t     mem_response
);
    import dcache_pkg::*;

    int fail_count = 0;   // read by the testbench

    // everything quiet one cycle after a reset edge
    reset_idle: assert property (@(posedge clock)
        reset |=> !stall && !resp_valid && mem_command == cmd_none)
        else begin
            fail_count++;
            $error("outputs active after reset");
        end

    // a write-back leaves its entry once memory takes it
    store_once: assert property (@(posedge clock) disable iff (reset)
        mem_command == cmd_store && mem_response != tag_none
        |=> !(mem_command == cmd_store && mem_addr == $past(mem_addr)))
        else begin
            fail_count++;
            $error("accepted write-back was sent to memory again");
        end

    // an accepted refill waits for its tag instead of retrying
    load_once: assert property (@(posedge clock) disable iff (reset)
        mem_command == cmd_load && mem_response != tag_none
        |=> !(mem_command == cmd_load && mem_addr == $past(mem_addr)))
        else begin
            fail_count++;
            $error("accepted refill was sent to memory again");
        end

    stall_release: assert property (@(posedge clock) disable iff (reset)
        $fell(stall) |-> resp_valid)
        else begin
            fail_count++;
            $error("stall dropped without a response");
        end

    resp_unstalled: assert property (@(posedge clock) disable iff (reset)
        resp_valid |-> !stall)
        else begin
            fail_count++;
            $error("response given while stalled");
        end

endmodule

//--- testbench/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int num_lines     = 8;
    localparam int num_mshr      = 4;
    localparam int clock_period  = 100;
    localparam int reset_cycles  = 5;
    localparam int directed_ops  = 16;
    localparam int random_ops    = 48;
    localparam int cycles_per_op = 400;
    localparam int seed          = 95;
    localparam int index_bits    = $clog2(num_lines);

    logic         clock;
    logic         reset;
    logic         req_valid;
    logic         req_store;
    addr_t        req_addr;
    mem_size_e    req_size;
    logic [31:0]  req_wdata;
    logic         stall;
    logic         resp_valid;
    logic [31:0]  resp_rdata;
    mem_command_e mem_command;
    addr_t        mem_addr;
    block_t       mem_wdata;
    mem_tag_t     mem_response;
    block_t       mem_rdata;
    mem_tag_t     mem_rtag;

    integer stim_state  = seed;
    integer delay_state = seed;   // separate stream for memory latency

    block_t   mem_image [addr_t];        // lines written back to memory
    block_t   expected_image [addr_t];   // scoreboard, byte accurate
    mem_tag_t ret_tag [$];
    block_t   ret_data [$];
    int       ret_due [$];
    int       cycle_count = 0;
    int       delay;
    int       due;
    mem_tag_t next_tag = 4'd1;
    addr_t    last_load_addr;

    logic [num_lines-1:0] model_valid;   // which lines the cache should hold
    addr_t                model_line [num_lines];

    dcache_top #(.num_lines(num_lines), .num_mshr(num_mshr)) dut (.*);

    bind dcache_top dcache_checker u_checker (
        .clock        (clock),
        .reset        (reset),
        .stall        (stall),
        .resp_valid   (resp_valid),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .mem_response (mem_response)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    function automatic addr_t line_of(addr_t a);
        return {a[31:block_offset_bits], {block_offset_bits{1'b0}}};
    endfunction

    // starting contents, different for every line address
    function automatic block_t initial_line(addr_t line);
        block_t b;
        b.words[1] = line ^ 32'h5a5a_0f0f;
        b.words[0] = {line[15:0], line[31:16]} + 32'h1357_9bdf;
        return b;
    endfunction

    function automatic block_t memory_line(addr_t line);
        if (mem_image.exists(line))
            return mem_image[line];
        return initial_line(line);
    endfunction

    function automatic block_t expected_line(addr_t line);
        if (expected_image.exists(line))
            return expected_image[line];
        return initial_line(line);
    endfunction

    function automatic int size_bits(mem_size_e size);
        case (size)
            size_byte: return 8;
            size_half: return 16;
            default:   return 32;
        endcase
    endfunction

    function automatic logic [31:0] expected_value(addr_t a, mem_size_e size);
        block_t      line;
        logic [63:0] shifted;
        line    = expected_line(line_of(a));
        shifted = line.raw >> (8 * a[2:0]);
        case (size)
            size_byte: return {24'h0, shifted[7:0]};   // loads are zero extended
            size_half: return {16'h0, shifted[15:0]};
            default:   return shifted[31:0];
        endcase
    endfunction

    function automatic void record_store(addr_t a, mem_size_e size, logic [31:0] data);
        block_t      line;
        logic [63:0] mask;
        line = expected_line(line_of(a));
        mask = ((64'h1 << size_bits(size)) - 64'h1) << (8 * a[2:0]);
        line.raw = (line.raw & ~mask) | ((64'(data) << (8 * a[2:0])) & mask);
        expected_image[line_of(a)] = line;
    endfunction

    // tagged memory, accepts every command at once and returns loads in order
    always @(posedge clock) begin
        #1;
        cycle_count++;
        mem_response = tag_none;
        mem_rtag     = tag_none;
        mem_rdata    = '0;
        if (!reset && mem_command != cmd_none) begin
            mem_response = next_tag;
            if (mem_command == cmd_store) begin
                assert (mem_wdata == expected_line(mem_addr))
                else abort_run($sformatf(
                    "Mismatch at %0t ns: write-back of %08h is %016h, expected %016h",
                    $time, mem_addr, mem_wdata, expected_line(mem_addr)));
                mem_image[mem_addr] = mem_wdata;
            end else begin
                last_load_addr = mem_addr;
                delay = 1 + ($unsigned($random(delay_state)) % 6);
                due = cycle_count + delay;
                if (ret_due.size() > 0 && due <= ret_due[$])
                    due = ret_due[$] + 1;
                ret_tag.push_back(next_tag);
                ret_data.push_back(memory_line(mem_addr));
                ret_due.push_back(due);
            end
            next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
        end
        if (ret_due.size() > 0 && ret_due[0] == cycle_count) begin
            mem_rtag  = ret_tag.pop_front();
            mem_rdata = ret_data.pop_front();
            void'(ret_due.pop_front());
        end
    end

    // one request, held until the DUT answers
    task automatic run_op(input logic store, input addr_t a, input mem_size_e size,
                          input logic [31:0] wdata);
        logic [index_bits-1:0] idx;
        logic                  expect_hit;
        int                    waited;
        idx        = a[block_offset_bits +: index_bits];
        expect_hit = model_valid[idx] && model_line[idx] == line_of(a);
        req_valid  = 1'b1;
        req_store  = store;
        req_addr   = a;
        req_size   = size;
        req_wdata  = wdata;
        waited     = 0;
        do begin
            @(posedge clock);
            #1;
            waited++;
            if (waited == 1)
                assert (stall == !expect_hit)
                else abort_run($sformatf("Mismatch at %0t ns: stall %b for %08h, expected %b",
                                         $time, stall, a, !expect_hit));
        end while (!resp_valid);
        req_valid = 1'b0;
        if (expect_hit)
            assert (waited == 1)
            else abort_run($sformatf("Mismatch at %0t ns: hit on %08h answered after %0d cycles",
                                     $time, a, waited));
        else
            assert (last_load_addr == line_of(a))
            else abort_run($sformatf("Mismatch at %0t ns: refill of %08h, expected %08h",
                                     $time, last_load_addr, line_of(a)));
        if (store)
            record_store(a, size, wdata);
        else
            assert (resp_rdata == expected_value(a, size))
            else abort_run($sformatf("Mismatch at %0t ns: load %08h gave %08h, expected %08h",
                                     $time, a, resp_rdata, expected_value(a, size)));
        model_valid[idx] = 1'b1;
        model_line[idx]  = line_of(a);
    endtask

    always @(negedge clock) begin
        if (dut.u_checker.fail_count != 0)
            abort_run("A checker assertion failed on the DUT ports");
    end

    initial begin : watchdog
        #(clock_period * (reset_cycles + cycles_per_op * (directed_ops + random_ops)));
        abort_run("Timeout: the DUT stopped answering requests");
    end

    initial begin : stimulus
        logic [31:0] r;
        addr_t       a;
        mem_size_e   size;
        reset        = 1'b1;
        req_valid    = 1'b0;
        req_store    = 1'b0;
        req_addr     = '0;
        req_size     = size_byte;
        req_wdata    = '0;
        mem_response = tag_none;
        mem_rdata    = '0;
        mem_rtag     = tag_none;
        model_valid  = '0;
        repeat (reset_cycles) @(posedge clock);
        #1;
        reset = 1'b0;

        run_op(1'b0, 32'h0000_100c, size_word, '0);            // cold miss
        run_op(1'b0, 32'h0000_1009, size_byte, '0);
        run_op(1'b1, 32'h0000_1009, size_byte, 32'h0000_00ab); // store hits
        run_op(1'b1, 32'h0000_100e, size_half, 32'h0000_1234);
        run_op(1'b0, 32'h0000_100c, size_word, '0);
        run_op(1'b0, 32'h0000_1008, size_half, '0);
        run_op(1'b0, 32'h0000_1009, size_byte, '0);
        run_op(1'b0, 32'h0000_2008, size_word, '0);            // evicts the dirty line
        run_op(1'b0, 32'h0000_100c, size_word, '0);            // reload after write-back
        run_op(1'b0, 32'h0000_1008, size_word, '0);
        run_op(1'b1, 32'h0000_3010, size_word, 32'hdead_beef); // store miss
        run_op(1'b0, 32'h0000_3010, size_word, '0);
        run_op(1'b0, 32'h0000_3012, size_half, '0);
        run_op(1'b0, 32'h0000_3013, size_byte, '0);
        run_op(1'b1, 32'h0000_3015, size_byte, 32'h0000_005c);
        run_op(1'b0, 32'h0000_3014, size_word, '0);

        // a few tags over four indices, so lines keep evicting each other
        for (int i = 0; i < random_ops; i++) begin
            r = $random(stim_state);
            a = 32'h0001_0000 | (r & 32'h0000_00df);
            size = (r[9:8] == 2'b11) ? size_word : mem_size_e'(r[9:8]);
            if (size == size_half)
                a[0] = 1'b0;
            if (size == size_word)
                a[1:0] = 2'b00;
            run_op(r[10], a, size, $random(stim_state));
        end

        repeat (2) @(posedge clock);
        if (dut.u_checker.fail_count == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            abort_run("A checker assertion failed on the DUT ports");
        end
    end

endmodule

//--- build.f
logic/dcache_pkg.sv
logic/mshr_if.sv
logic/dcache_lines.sv
logic/dcache_control.sv
logic/mshr_alloc.sv
logic/mshr_entry.sv
logic/mem_issue.sv
logic/dcache_top.sv
testbench/dcache_checker.sv
testbench/dcache_tb.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - logic/dcache_pkg.sv
  - logic/mshr_if.sv
  - logic/dcache_lines.sv
  - logic/dcache_control.sv
  - logic/mshr_alloc.sv
  - logic/mshr_entry.sv
  - logic/mem_issue.sv
  - logic/dcache_top.sv
  - target: test
    files:
      - testbench/dcache_checker.sv
      - testbench/dcache_tb.sv
